//--- flist.f
+incdir+include
logic/ctrlPkg.sv
logic/instructionRegister.sv
logic/aluGroupDecoder.sv
logic/loadStoreDecoder.sv
logic/jumpDecoder.sv
logic/interruptController.sv
logic/debugSequencer.sv
logic/opxMultiplexer.sv
logic/controlUnit.sv
testbench/controlUnitTb.sv

//--- include/ctrl_macros.svh
`ifndef CTRL_MACROS_SVH
`define CTRL_MACROS_SVH

// Width of one instruction word.
`define INSTR_WIDTH 16

// Field positions inside the instruction word. Bits 1..0 are spare.
`define GROUP_MSB 15
`define GROUP_LSB 14
`define OPCODE_MSB 13
`define OPCODE_LSB 10
`define MODE_MSB 9
`define MODE_LSB 8
`define ARGB_MSB 7
`define ARGB_LSB 4
`define ARGA_MSB 3
`define ARGA_LSB 2

// System group opcodes that touch the interrupt state.
`define SYS_OP_EI 4'd1
`define SYS_OP_DI 4'd2
`define SYS_OP_RETI 4'd3

`endif

//--- logic/aluGroupDecoder.sv
`timescale 1ns/1ps

module aluGroupDecoder (
	input  ctrlPkg::instrFieldsT fields,
	output ctrlPkg::aluBundleT   aluBundle
);
	import ctrlPkg::*;

	always_comb begin
		aluBundle.aluOp   = aluOpT'(fields.opcode);
		aluBundle.aluASrc = ALUA_REG_A;
		// Mode bit 0 turns the second operand into an immediate.
		aluBundle.aluBSrc = fields.mode[0] ? ALUB_ARGB : ALUB_REG_B;
		// A plain move leaves the condition codes alone.
		aluBundle.cclLoad = (aluBundle.aluOp != ALU_MOV);
		aluBundle.regAAddr = REGA_ADDR_ARGA;
		aluBundle.regBAddr = REGB_ADDR_ARGB;
		// Compare only sets flags, nothing is written back.
		if (aluBundle.aluOp == ALU_CMP) begin
			aluBundle.regSeq = REG_SEQ_NONE;
		end else begin
			aluBundle.regSeq = REG_SEQ_WRITE_A;
		end
	end

endmodule

//--- logic/controlUnit.sv
`timescale 1ns/1ps
`include "ctrl_macros.svh"

module controlUnit (
	input  logic                     clk,
	input  logic                     arstN,
	input  logic                     instrValid,
	input  logic [`INSTR_WIDTH-1:0]  instr,
	input  ctrlPkg::flagsT           flags,
	input  logic                     irq,
	input  logic                     debugMode,
	input  logic                     dbgCmdValid,
	input  ctrlPkg::dbgCmdT          dbgCmd,
	output logic                     ctrlValid,
	output ctrlPkg::controlWordT     ctrlWord,
	output logic                     intTaken
);
	import ctrlPkg::*;

	logic        issue;
	logic        dbgStep;
	instrGroupT  group;
	instrFieldsT fields;
	aluBundleT   aluBundle;
	ldsBundleT   ldsBundle;
	jmpBundleT   jmpBundle;
	intBundleT   intBundle;
	dbgBundleT   dbgBundle;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Front ends.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	instructionRegister instructionRegister_inst (
		.clk(clk), .arstN(arstN), .instrValid(instrValid), .instr(instr),
		.debugMode(debugMode), .issue(issue), .group(group), .fields(fields)
	);

	debugSequencer debugSequencer_inst (
		.clk(clk), .arstN(arstN), .debugMode(debugMode), .dbgCmdValid(dbgCmdValid),
		.dbgCmd(dbgCmd), .dbgStep(dbgStep), .dbgBundle(dbgBundle)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Group decoders and interrupt state.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	aluGroupDecoder aluGroupDecoder_inst (.fields(fields), .aluBundle(aluBundle));

	loadStoreDecoder loadStoreDecoder_inst (.fields(fields), .ldsBundle(ldsBundle));

	jumpDecoder jumpDecoder_inst (.fields(fields), .flags(flags), .jmpBundle(jmpBundle));

	interruptController interruptController_inst (
		.clk(clk), .arstN(arstN), .irq(irq), .issue(issue), .group(group),
		.fields(fields), .intBundle(intBundle), .intTaken(intTaken)
	);

	// Output register stage.
	opxMultiplexer opxMultiplexer_inst (
		.clk(clk), .arstN(arstN), .issue(issue), .dbgStep(dbgStep),
		.group(group), .fields(fields), .aluBundle(aluBundle),
		.ldsBundle(ldsBundle), .jmpBundle(jmpBundle), .intBundle(intBundle),
		.dbgBundle(dbgBundle), .ctrlValid(ctrlValid), .ctrlWord(ctrlWord)
	);

endmodule

//--- logic/ctrlPkg.sv
package ctrlPkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Instruction side.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [1:0] {
		GROUP_SYSTEM, GROUP_LOAD_STORE, GROUP_JUMP, GROUP_ARITH_LOGIC
	} instrGroupT;

	typedef struct packed {
		logic [3:0] opcode;
		logic [1:0] mode;
		logic [1:0] argA;
		logic [3:0] argB;
	} instrFieldsT;

	typedef struct packed {
		logic zero;
		logic carry;
		logic negative;
	} flagsT;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Control field codes.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [3:0] {
		ALU_MOV, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_CMP, ALU_NOT,
		ALU_SHL, ALU_SHR, ALU_ROL, ALU_ROR, ALU_ADC, ALU_SBC, ALU_INC, ALU_DEC
	} aluOpT;

	typedef enum logic [2:0] {ALUA_REG_A, ALUA_PC, ALUA_ZERO} aluASrcT;
	typedef enum logic [2:0] {ALUB_REG_B, ALUB_ARGB, ALUB_ZERO} aluBSrcT;
	typedef enum logic [2:0] {ADDR_PC_A, ADDR_REG_B, ADDR_ALU_R} addrBusT;
	typedef enum logic [1:0] {BUS_NONE, BUS_READ, BUS_WRITE} busSeqT;
	typedef enum logic [1:0] {DATA_REGA_DOUT, DATA_ALU_R, DATA_DIN} dataBusT;
	typedef enum logic [1:0] {PC_BASE_PC_A, PC_BASE_REG_B} pcBaseT;
	typedef enum logic [1:0] {PC_OFFSET_2, PC_OFFSET_ARG} pcOffsetT;
	typedef enum logic [2:0] {
		PC_NEXT_SEQUENTIAL, PC_NEXT_VECTOR, PC_NEXT_RETURN, PC_NEXT_HOLD
	} pcNextT;
	typedef enum logic [1:0] {CC_KEEP, CC_SAVE, CC_RESTORE} ccRegT;
	typedef enum logic [3:0] {
		REG_SEQ_NONE, REG_SEQ_WRITE_A, REG_SEQ_READ_A, REG_SEQ_READ_B
	} regSeqT;
	typedef enum logic [1:0] {REGA_DIN_DIN, REGA_DIN_ALU_R, REGA_DIN_PC} regADinT;
	typedef enum logic [1:0] {REGA_ADDR_ARGA, REGA_ADDR_LINK} regAAddrT;
	typedef enum logic [2:0] {REGB_ADDR_ARGB, REGB_ADDR_SP} regBAddrT;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bundles produced by the decoders.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef struct packed {
		aluOpT aluOp; aluASrcT aluASrc; aluBSrcT aluBSrc; logic cclLoad;
		regAAddrT regAAddr; regBAddrT regBAddr; regSeqT regSeq;
	} aluBundleT;

	typedef struct packed {
		addrBusT addrBus; aluOpT aluOp; aluASrcT aluASrc; aluBSrcT aluBSrc;
		busSeqT busSeq; logic byteSel; dataBusT dataBus; pcOffsetT pcOffset;
		regSeqT regSeq; regAAddrT regAAddr; regADinT regADin; regBAddrT regBAddr;
	} ldsBundleT;

	typedef struct packed {
		addrBusT addrBus; aluBSrcT aluBSrc; busSeqT busSeq; pcBaseT pcBase;
		pcOffsetT pcOffset; regSeqT regSeq; regADinT regADin;
		regAAddrT regAAddr; regBAddrT regBAddr;
	} jmpBundleT;

	typedef struct packed {
		ccRegT ccReg; pcNextT pcNext;
	} intBundleT;

	typedef struct packed {
		addrBusT addrBus; logic [3:0] argB; busSeqT busSeq; regSeqT regSeq;
	} dbgCmdT;

	typedef struct packed {
		addrBusT addrBus; logic [3:0] argB; busSeqT busSeq;
		ccRegT ccReg; pcNextT pcNext; regSeqT regSeq;
	} dbgBundleT;

	// The complete word handed to the datapath, 43 bits.
	typedef struct packed {
		addrBusT addrBus; aluOpT aluOp; aluASrcT aluASrc; aluBSrcT aluBSrc;
		logic [3:0] argB; busSeqT busSeq; logic byteSel; logic cclLoad;
		ccRegT ccReg; dataBusT dataBus; pcBaseT pcBase; pcNextT pcNext;
		pcOffsetT pcOffset; regSeqT regSeq; regAAddrT regAAddr;
		regADinT regADin; regBAddrT regBAddr;
	} controlWordT;

endpackage

//--- logic/debugSequencer.sv
`timescale 1ns/1ps

module debugSequencer (
	input  logic               clk,
	input  logic               arstN,
	input  logic               debugMode,
	input  logic               dbgCmdValid,
	input  ctrlPkg::dbgCmdT    dbgCmd,
	output logic               dbgStep,
	output ctrlPkg::dbgBundleT dbgBundle
);
	import ctrlPkg::*;

	logic   accept;
	dbgCmdT cmdQ;

	// Commands count only while the core sits in debug mode.
	assign accept = dbgCmdValid && debugMode;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			dbgStep <= 1'b0;
		end else begin
			dbgStep <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			cmdQ <= dbgCmd;
		end
	end

	// The PC is frozen and the condition codes are preserved during a step.
	always_comb begin
		dbgBundle.addrBus = cmdQ.addrBus;
		dbgBundle.argB    = cmdQ.argB;
		dbgBundle.busSeq  = cmdQ.busSeq;
		dbgBundle.regSeq  = cmdQ.regSeq;
		dbgBundle.ccReg   = CC_KEEP;
		dbgBundle.pcNext  = PC_NEXT_HOLD;
	end

endmodule

//--- logic/instructionRegister.sv
`timescale 1ns/1ps
`include "ctrl_macros.svh"

module instructionRegister (
	input  logic                      clk,
	input  logic                      arstN,
	input  logic                      instrValid,
	input  logic [`INSTR_WIDTH-1:0]   instr,
	input  logic                      debugMode,
	output logic                      issue,
	output ctrlPkg::instrGroupT       group,
	output ctrlPkg::instrFieldsT      fields
);
	import ctrlPkg::*;

	logic capture;

	// Instructions are only accepted outside debug mode.
	assign capture = instrValid && !debugMode;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			issue <= 1'b0;
		end else begin
			issue <= capture;
		end
	end

	// The split fields stay put until the next accepted instruction.
	always_ff @(posedge clk) begin
		if (capture) begin
			group         <= instrGroupT'(instr[`GROUP_MSB:`GROUP_LSB]);
			fields.opcode <= instr[`OPCODE_MSB:`OPCODE_LSB];
			fields.mode   <= instr[`MODE_MSB:`MODE_LSB];
			fields.argA   <= instr[`ARGA_MSB:`ARGA_LSB];
			fields.argB   <= instr[`ARGB_MSB:`ARGB_LSB];
		end
	end

endmodule

//--- logic/interruptController.sv
`timescale 1ns/1ps
`include "ctrl_macros.svh"

module interruptController (
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 irq,
	input  logic                 issue,
	input  ctrlPkg::instrGroupT  group,
	input  ctrlPkg::instrFieldsT fields,
	output ctrlPkg::intBundleT   intBundle,
	output logic                 intTaken
);
	import ctrlPkg::*;

	logic pending;
	logic enable;
	logic isSystem;
	logic take;

	assign isSystem = (group == GROUP_SYSTEM);
	assign take     = issue && pending && enable;

	// The bundle is sampled by the multiplexer on the issue edge.
	always_comb begin
		if (pending && enable) begin
			intBundle = '{ccReg: CC_SAVE, pcNext: PC_NEXT_VECTOR};
		end else if (isSystem && fields.opcode == `SYS_OP_RETI) begin
			intBundle = '{ccReg: CC_RESTORE, pcNext: PC_NEXT_RETURN};
		end else begin
			intBundle = '{ccReg: CC_KEEP, pcNext: PC_NEXT_SEQUENTIAL};
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pending  <= 1'b0;
			enable   <= 1'b0;
			intTaken <= 1'b0;
		end else begin
			intTaken <= take;
			pending  <= irq || (pending && !take);
			if (take) begin
				enable <= 1'b0;
			end else if (issue && isSystem && fields.opcode == `SYS_OP_EI) begin
				enable <= 1'b1;
			end else if (issue && isSystem && fields.opcode == `SYS_OP_DI) begin
				enable <= 1'b0;
			end
		end
	end

	// The enable update decodes the issued instruction, so it must be fully known.
	assert property (@(posedge clk) disable iff (!arstN) issue |-> !$isunknown({group, fields}))
		else $error("Interrupt state updated from an unknown instruction");

endmodule

//--- logic/jumpDecoder.sv
`timescale 1ns/1ps

module jumpDecoder (
	input  ctrlPkg::instrFieldsT fields,
	input  ctrlPkg::flagsT       flags,
	output ctrlPkg::jmpBundleT   jmpBundle
);
	import ctrlPkg::*;

	logic taken;
	logic link;

	// Condition select: always, zero, carry, negative.
	always_comb begin
		case (fields.opcode[1:0])
			2'd0:    taken = 1'b1;
			2'd1:    taken = flags.zero;
			2'd2:    taken = flags.carry;
			default: taken = flags.negative;
		endcase
	end

	assign link = fields.mode[1] && taken;

	always_comb begin
		jmpBundle.addrBus  = ADDR_PC_A;
		jmpBundle.aluBSrc  = ALUB_ARGB;
		jmpBundle.busSeq   = BUS_NONE;
		jmpBundle.regBAddr = REGB_ADDR_ARGB;
		jmpBundle.pcBase   = PC_BASE_PC_A;
		jmpBundle.pcOffset = PC_OFFSET_2;
		if (taken) begin
			jmpBundle.pcBase   = fields.mode[0] ? PC_BASE_REG_B : PC_BASE_PC_A;
			jmpBundle.pcOffset = PC_OFFSET_ARG;
		end
		// A taken call saves the return address in the link register.
		jmpBundle.regSeq   = link ? REG_SEQ_WRITE_A : REG_SEQ_NONE;
		jmpBundle.regADin  = link ? REGA_DIN_PC : REGA_DIN_DIN;
		jmpBundle.regAAddr = link ? REGA_ADDR_LINK : REGA_ADDR_ARGA;
	end

endmodule

//--- logic/loadStoreDecoder.sv
`timescale 1ns/1ps

module loadStoreDecoder (
	input  ctrlPkg::instrFieldsT fields,
	output ctrlPkg::ldsBundleT   ldsBundle
);
	import ctrlPkg::*;

	logic isStore;

	assign isStore = fields.mode[1];

	always_comb begin
		// The ALU forms the effective address from the argB offset.
		ldsBundle.addrBus  = ADDR_ALU_R;
		ldsBundle.aluOp    = ALU_ADD;
		ldsBundle.aluASrc  = ALUA_ZERO;
		ldsBundle.aluBSrc  = ALUB_ARGB;
		ldsBundle.byteSel  = fields.mode[0];
		ldsBundle.pcOffset = PC_OFFSET_2;
		ldsBundle.regAAddr = REGA_ADDR_ARGA;
		ldsBundle.regBAddr = REGB_ADDR_ARGB;
		ldsBundle.regADin  = REGA_DIN_DIN;
		if (isStore) begin
			ldsBundle.busSeq  = BUS_WRITE;
			ldsBundle.dataBus = DATA_REGA_DOUT;
			ldsBundle.regSeq  = REG_SEQ_READ_A;
		end else begin
			ldsBundle.busSeq  = BUS_READ;
			ldsBundle.dataBus = DATA_DIN;
			ldsBundle.regSeq  = REG_SEQ_WRITE_A;
		end
	end

endmodule

//--- logic/opxMultiplexer.sv
`timescale 1ns/1ps

module opxMultiplexer (
	input  logic                  clk,
	input  logic                  arstN,
	input  logic                  issue,
	input  logic                  dbgStep,
	input  ctrlPkg::instrGroupT   group,
	input  ctrlPkg::instrFieldsT  fields,
	input  ctrlPkg::aluBundleT    aluBundle,
	input  ctrlPkg::ldsBundleT    ldsBundle,
	input  ctrlPkg::jmpBundleT    jmpBundle,
	input  ctrlPkg::intBundleT    intBundle,
	input  ctrlPkg::dbgBundleT    dbgBundle,
	output logic                  ctrlValid,
	output ctrlPkg::controlWordT  ctrlWord
);
	import ctrlPkg::*;

	controlWordT nextWord;

	always_comb begin
		// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
		// Idle defaults, which are also the system group word.
		// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
		nextWord.addrBus  = ADDR_PC_A;
		nextWord.aluOp    = ALU_MOV;
		nextWord.aluASrc  = ALUA_REG_A;
		nextWord.aluBSrc  = ALUB_REG_B;
		nextWord.argB     = fields.argB;
		nextWord.busSeq   = BUS_NONE;
		nextWord.byteSel  = 1'b0;
		nextWord.cclLoad  = 1'b0;
		nextWord.ccReg    = intBundle.ccReg;
		nextWord.dataBus  = DATA_REGA_DOUT;
		nextWord.pcBase   = PC_BASE_PC_A;
		nextWord.pcNext   = intBundle.pcNext;
		nextWord.pcOffset = PC_OFFSET_2;
		nextWord.regSeq   = REG_SEQ_NONE;
		nextWord.regAAddr = REGA_ADDR_ARGA;
		nextWord.regADin  = REGA_DIN_DIN;
		nextWord.regBAddr = REGB_ADDR_ARGB;

		if (dbgStep) begin
			nextWord.addrBus = dbgBundle.addrBus;
			nextWord.argB    = dbgBundle.argB;
			nextWord.busSeq  = dbgBundle.busSeq;
			nextWord.ccReg   = dbgBundle.ccReg;
			nextWord.pcNext  = dbgBundle.pcNext;
			nextWord.regSeq  = dbgBundle.regSeq;
		end else begin
			case (group)
				GROUP_LOAD_STORE: begin
					nextWord.addrBus  = ldsBundle.addrBus;
					nextWord.aluOp    = ldsBundle.aluOp;
					nextWord.aluASrc  = ldsBundle.aluASrc;
					nextWord.aluBSrc  = ldsBundle.aluBSrc;
					nextWord.busSeq   = ldsBundle.busSeq;
					nextWord.byteSel  = ldsBundle.byteSel;
					nextWord.dataBus  = ldsBundle.dataBus;
					nextWord.pcOffset = ldsBundle.pcOffset;
					nextWord.regSeq   = ldsBundle.regSeq;
					nextWord.regAAddr = ldsBundle.regAAddr;
					nextWord.regADin  = ldsBundle.regADin;
					nextWord.regBAddr = ldsBundle.regBAddr;
				end
				GROUP_JUMP: begin
					nextWord.addrBus  = jmpBundle.addrBus;
					nextWord.aluBSrc  = jmpBundle.aluBSrc;
					nextWord.busSeq   = jmpBundle.busSeq;
					nextWord.pcBase   = jmpBundle.pcBase;
					nextWord.pcOffset = jmpBundle.pcOffset;
					nextWord.regSeq   = jmpBundle.regSeq;
					nextWord.regADin  = jmpBundle.regADin;
					nextWord.regAAddr = jmpBundle.regAAddr;
					nextWord.regBAddr = jmpBundle.regBAddr;
				end
				GROUP_ARITH_LOGIC: begin
					nextWord.aluOp    = aluBundle.aluOp;
					nextWord.aluASrc  = aluBundle.aluASrc;
					nextWord.aluBSrc  = aluBundle.aluBSrc;
					nextWord.cclLoad  = aluBundle.cclLoad;
					nextWord.dataBus  = DATA_ALU_R;
					nextWord.regSeq   = aluBundle.regSeq;
					nextWord.regAAddr = aluBundle.regAAddr;
					nextWord.regADin  = REGA_DIN_ALU_R;
					nextWord.regBAddr = aluBundle.regBAddr;
				end
				default: begin
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ctrlValid <= 1'b0;
			ctrlWord  <= '0;
		end else begin
			ctrlValid <= issue || dbgStep;
			if (issue || dbgStep) begin
				ctrlWord <= nextWord;
			end
		end
	end

	// Debug mode gates the two front ends, so they never issue in the same cycle.
	assert property (@(posedge clk) disable iff (!arstN) !(issue && dbgStep))
		else $error("Instruction issue collided with a debug step");

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the control unit simulation with Verilator.
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module controlUnitTb -o controlUnitSim
./obj_dir/controlUnitSim | tee sim.log

if grep -q "^TEST OK$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed, see sim.log"
	exit 1
fi

//--- testbench/controlUnitTb.sv
`timescale 1ns/1ps
`include "ctrl_macros.svh"

module controlUnitTb;
	import ctrlPkg::*;

	localparam int STIM_CYCLES = 2000;
	localparam int DRAIN_CYCLES = 4;
	// Stimulus plus reset and drain, with plenty of margin.
	localparam int TIMEOUT_CYCLES = 3000;

	typedef struct packed {
		logic        isDbg;
		logic [15:0] instr;
		dbgCmdT      cmd;
	} requestT;

	logic clk, arstN, instrValid, irq, debugMode, dbgCmdValid;
	logic [`INSTR_WIDTH-1:0] instr;
	flagsT flags;
	dbgCmdT dbgCmd;
	logic ctrlValid, intTaken;
	controlWordT ctrlWord;

	// Reference model state.
	requestT     reqQueue[$];
	logic        pending, enable, expValid, expTaken;
	controlWordT expWord;
	int          cycleCount, checkCount, errorCount, takenCount, debugCount;

	controlUnit controlUnit_inst (
		.clk(clk), .arstN(arstN), .instrValid(instrValid), .instr(instr), .flags(flags),
		.irq(irq), .debugMode(debugMode), .dbgCmdValid(dbgCmdValid), .dbgCmd(dbgCmd),
		.ctrlValid(ctrlValid), .ctrlWord(ctrlWord), .intTaken(intTaken)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic checkValue(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		checkCount = checkCount + 1;
		if (actual !== expected) begin
			errorCount = errorCount + 1;
			$display("** Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Expected control words.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Idle values, which are also the whole system group word.
	function automatic controlWordT defaultWord(input logic [3:0] argB);
		controlWordT w;
		w = '0;
		w.addrBus = ADDR_PC_A;
		w.aluOp = ALU_MOV;
		w.aluASrc = ALUA_REG_A;
		w.aluBSrc = ALUB_REG_B;
		w.argB = argB;
		w.busSeq = BUS_NONE;
		w.dataBus = DATA_REGA_DOUT;
		w.pcBase = PC_BASE_PC_A;
		w.pcOffset = PC_OFFSET_2;
		w.regSeq = REG_SEQ_NONE;
		w.regAAddr = REGA_ADDR_ARGA;
		w.regADin = REGA_DIN_DIN;
		w.regBAddr = REGB_ADDR_ARGB;
		w.ccReg = CC_KEEP;
		w.pcNext = PC_NEXT_SEQUENTIAL;
		return w;
	endfunction

	function automatic controlWordT debugWord(input dbgCmdT cmd);
		controlWordT w;
		w = defaultWord(cmd.argB);
		w.addrBus = cmd.addrBus;
		w.busSeq = cmd.busSeq;
		w.regSeq = cmd.regSeq;
		w.pcNext = PC_NEXT_HOLD;
		return w;
	endfunction

	function automatic controlWordT instrWord(input logic [15:0] word, input flagsT f,
			input logic intTake);
		controlWordT w;
		instrGroupT  grp;
		logic [3:0]  opcode;
		logic [1:0]  mode;
		logic        taken;
		grp = instrGroupT'(word[`GROUP_MSB:`GROUP_LSB]);
		opcode = word[`OPCODE_MSB:`OPCODE_LSB];
		mode = word[`MODE_MSB:`MODE_LSB];
		w = defaultWord(word[`ARGB_MSB:`ARGB_LSB]);
		case (grp)
			GROUP_LOAD_STORE: begin
				w.addrBus = ADDR_ALU_R;
				w.aluOp = ALU_ADD;
				w.aluASrc = ALUA_ZERO;
				w.aluBSrc = ALUB_ARGB;
				w.byteSel = mode[0];
				w.busSeq = mode[1] ? BUS_WRITE : BUS_READ;
				w.dataBus = mode[1] ? DATA_REGA_DOUT : DATA_DIN;
				w.regSeq = mode[1] ? REG_SEQ_READ_A : REG_SEQ_WRITE_A;
			end
			GROUP_JUMP: begin
				case (opcode[1:0])
					2'd0: taken = 1'b1;
					2'd1: taken = f.zero;
					2'd2: taken = f.carry;
					default: taken = f.negative;
				endcase
				w.aluBSrc = ALUB_ARGB;
				if (taken) begin
					w.pcBase = mode[0] ? PC_BASE_REG_B : PC_BASE_PC_A;
					w.pcOffset = PC_OFFSET_ARG;
				end
				if (taken && mode[1]) begin
					w.regSeq = REG_SEQ_WRITE_A;
					w.regADin = REGA_DIN_PC;
					w.regAAddr = REGA_ADDR_LINK;
				end
			end
			GROUP_ARITH_LOGIC: begin
				w.aluOp = aluOpT'(opcode);
				w.aluBSrc = mode[0] ? ALUB_ARGB : ALUB_REG_B;
				w.cclLoad = (w.aluOp != ALU_MOV);
				w.dataBus = DATA_ALU_R;
				w.regADin = REGA_DIN_ALU_R;
				w.regSeq = (w.aluOp == ALU_CMP) ? REG_SEQ_NONE : REG_SEQ_WRITE_A;
			end
			default: begin
			end
		endcase
		if (intTake) begin
			w.ccReg = CC_SAVE;
			w.pcNext = PC_NEXT_VECTOR;
		end else if (grp == GROUP_SYSTEM && opcode == `SYS_OP_RETI) begin
			w.ccReg = CC_RESTORE;
			w.pcNext = PC_NEXT_RETURN;
		end
		return w;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Model step, run just after each rising edge.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// A request sampled at one edge leaves the output register at the next one.
	task automatic stepModel();
		requestT    req;
		instrGroupT grp;
		logic [3:0] opcode;
		expValid = 1'b0;
		expTaken = 1'b0;
		if (reqQueue.size() != 0) begin
			req = reqQueue.pop_front();
			expValid = 1'b1;
			if (req.isDbg) begin
				expWord = debugWord(req.cmd);
				debugCount = debugCount + 1;
			end else begin
				grp = instrGroupT'(req.instr[`GROUP_MSB:`GROUP_LSB]);
				opcode = req.instr[`OPCODE_MSB:`OPCODE_LSB];
				expTaken = pending && enable;
				expWord = instrWord(req.instr, flags, expTaken);
				if (expTaken) begin
					enable = 1'b0;
					takenCount = takenCount + 1;
				end else if (grp == GROUP_SYSTEM && opcode == `SYS_OP_EI) begin
					enable = 1'b1;
				end else if (grp == GROUP_SYSTEM && opcode == `SYS_OP_DI) begin
					enable = 1'b0;
				end
			end
		end
		pending = irq || (pending && !expTaken);
		if (instrValid && !debugMode) begin
			req = '0;
			req.instr = instr;
			reqQueue.push_back(req);
		end
		if (dbgCmdValid && debugMode) begin
			req = '0;
			req.isDbg = 1'b1;
			req.cmd = dbgCmd;
			reqQueue.push_back(req);
		end
		checkValue("ctrlValid", 64'(ctrlValid), 64'(expValid));
		checkValue("intTaken", 64'(intTaken), 64'(expTaken));
		checkValue("ctrlWord", 64'(ctrlWord), 64'(expWord));
	endtask

	task automatic driveInputs();
		logic [31:0] r;
		if ($urandom_range(63) == 0) begin
			debugMode = !debugMode;
		end
		instrValid = ($urandom_range(9) < 6);
		r = $urandom;
		instr = r[15:0];
		// Bias towards the interrupt control opcodes of the system group.
		if ($urandom_range(3) == 0) begin
			instr[`GROUP_MSB:`GROUP_LSB] = 2'b00;
			instr[`OPCODE_MSB:`OPCODE_LSB] = {2'b00, r[17:16]};
		end
		irq = ($urandom_range(15) == 0);
		flags = flagsT'(r[20:18]);
		dbgCmdValid = ($urandom_range(9) < 6);
		r = $urandom;
		dbgCmd = dbgCmdT'(r[12:0]);
	endtask

	initial begin
		void'($urandom(67107));
		{arstN, instrValid, irq, debugMode, dbgCmdValid} = '0;
		instr = '0;
		flags = '0;
		dbgCmd = '0;
		{pending, enable, expValid, expTaken} = '0;
		expWord = '0;
		{cycleCount, checkCount, errorCount, takenCount, debugCount} = '0;
		repeat (8) @(posedge clk);
		#1;
		checkValue("ctrlValid", 64'(ctrlValid), 64'd0);
		checkValue("intTaken", 64'(intTaken), 64'd0);
		checkValue("ctrlWord", 64'(ctrlWord), 64'd0);
		#1 arstN = 1'b1;
		for (int cycle = 0; cycle < STIM_CYCLES + DRAIN_CYCLES; cycle++) begin
			@(posedge clk);
			#1;
			stepModel();
			#1;
			if (cycle < STIM_CYCLES) begin
				driveInputs();
			end else begin
				{instrValid, irq, dbgCmdValid} = '0;
			end
		end
		if (takenCount == 0 || debugCount == 0) begin
			errorCount = errorCount + 1;
			$display("No interrupt or no debug step was exercised during the run");
		end
		$display("Run finished: %0d checks, %0d errors, %0d interrupts, %0d debug words",
			checkCount, errorCount, takenCount, debugCount);
		if (errorCount == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
